// File: hw/control_config.svh
// control unit field widths and status flag bit positions

`ifndef CONTROL_CONFIG_SVH
`define CONTROL_CONFIG_SVH

// instruction byte split
`define OPCODE_WIDTH 5
`define BRANCH_WIDTH 3

// status register
`define FLAG_WIDTH 4

// flag bit positions in the status register
`define FLAGS_C 0
`define FLAGS_Z 1
`define FLAGS_N 2
`define FLAGS_V 3

`endif

// File: hw/controlPkg.sv
// control unit types covering opcodes, branch codes, datapath selects and sequencer states

`include "control_config.svh"

package controlPkg;

   typedef enum logic [`OPCODE_WIDTH-1:0] {
      ADD, ADDI, ADDIB, ADC, ADCI,          // add group
      SUB, SUBI, SUBIB, SUC, SUCI,          // subtract group
      CMP, CMPI,                            // no register write
      AND, OR, XOR, NOT, NAND, NOR,
      LSL, LSR, ASR, NEG,
      LUI, LLI,                             // immediate loads
      LDW, STW,                             // multi-cycle memory ops
      BRANCH                                // condition in low bits
   } opcodeT;

   typedef enum logic [`BRANCH_WIDTH-1:0] {
      BR, BNE, BE, BLT, BGE, BWL, RET, JMP
   } branchT;

   typedef enum logic [3:0] {
      FnA, FnADD, FnADC, FnSUB, FnNEG,
      FnAND, FnOR, FnXOR, FnNOT, FnNAND, FnNOR,
      FnLSL, FnLSR, FnASR,
      FnLUI, FnLLI
   } aluFunctionT;

   typedef enum logic {Op1Rd1, Op1Pc} op1SelectT;

   typedef enum logic {Op2Imm, Op2Rd2} op2SelectT;

   typedef enum logic {WdAlu, WdSys} wdSelectT;

   typedef enum logic {ImmLong, ImmShort} immSelectT;

   typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus} pcSelectT;

   typedef enum logic {LrSys, LrPc} lrSelectT;

   typedef enum logic {Rs1Ra, Rs1Rd} rs1SelectT;

   typedef enum logic {fetch, execute} majorStateT;

   typedef enum logic [2:0] {Cycle0, Cycle1, Cycle2, Cycle3, Cycle4} cycleT;

endpackage

// File: hw/cycleSequencer.sv
// major state and sub-cycle registers stepping the processor through fetch and execute

`timescale 1ns/1ps

module cycleSequencer (
   input  logic                   Clock,
   input  logic                   nReset,
   input  controlPkg::opcodeT     Opcode,
   output controlPkg::majorStateT State,
   output controlPkg::cycleT      Cycle
);

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         State <= controlPkg::fetch;
         Cycle <= controlPkg::Cycle0;
      end else begin
         case (State)
            controlPkg::fetch: begin
               if (Cycle inside {controlPkg::Cycle0, controlPkg::Cycle1, controlPkg::Cycle2}) begin
                  Cycle <= controlPkg::cycleT'(Cycle + 3'd1);
               end else begin
                  State <= controlPkg::execute;   // instruction register loaded in Cycle3
                  Cycle <= controlPkg::Cycle0;
               end
            end
            default: begin
               if (Cycle inside {controlPkg::Cycle1, controlPkg::Cycle2, controlPkg::Cycle3} ||
                   (Cycle == controlPkg::Cycle0 &&
                    Opcode inside {controlPkg::LDW, controlPkg::STW})) begin
                  Cycle <= controlPkg::cycleT'(Cycle + 3'd1);   // memory ops run to Cycle4
               end else begin
                  State <= controlPkg::fetch;
                  Cycle <= controlPkg::Cycle0;
               end
            end
         endcase
      end
   end

endmodule

// File: hw/flagUnit.sv
// status flag register with branch condition evaluation

`timescale 1ns/1ps
`include "control_config.svh"

module flagUnit (
   input  logic                   Clock,
   input  logic                   nReset,
   input  logic [`FLAG_WIDTH-1:0] Flags,
   input  logic                   StatusWe,
   input  controlPkg::branchT     BranchCode,
   output logic                   CFlag,
   output logic                   BranchTaken
);

   logic [`FLAG_WIDTH-1:0] statusReg;
   logic                   zFlag;
   logic                   nvDiffer;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         statusReg <= '0;
      end else if (StatusWe) begin
         statusReg <= Flags;   // ALU flags captured at end of execute
      end
   end

   assign CFlag    = statusReg[`FLAGS_C];
   assign zFlag    = statusReg[`FLAGS_Z];
   assign nvDiffer = statusReg[`FLAGS_N] ^ statusReg[`FLAGS_V];

   // Z polarity follows the datapath, which reports Z set on inequality
   always_comb begin
      case (BranchCode)
         controlPkg::BR, controlPkg::BWL: BranchTaken = 1'b1;
         controlPkg::BNE:                 BranchTaken = zFlag;
         controlPkg::BE:                  BranchTaken = ~zFlag;
         controlPkg::BLT:                 BranchTaken = nvDiffer;
         controlPkg::BGE:                 BranchTaken = ~nvDiffer;
         default:                         BranchTaken = 1'b0;   // RET and JMP
      endcase
   end

endmodule

// File: hw/datapathDecoder.sv
// datapath control decode for ALU, operand, register file, link and PC selects

`timescale 1ns/1ps

module datapathDecoder (
   input  controlPkg::majorStateT  State,
   input  controlPkg::cycleT       Cycle,
   input  controlPkg::opcodeT      Opcode,
   input  controlPkg::branchT      BranchCode,
   input  logic                    BranchTaken,
   output controlPkg::aluFunctionT AluOp,
   output controlPkg::op1SelectT   Op1Sel,
   output controlPkg::op2SelectT   Op2Sel,
   output controlPkg::immSelectT   ImmSel,
   output controlPkg::wdSelectT    WdSel,
   output controlPkg::pcSelectT    PcSel,
   output controlPkg::lrSelectT    LrSel,
   output controlPkg::rs1SelectT   Rs1Sel,
   output logic                    AluEn,
   output logic                    AluWe,
   output logic                    LrEn,
   output logic                    LrWe,
   output logic                    RegWe,
   output logic                    PcWe,
   output logic                    StatusWe
);

   logic aluClass;

   // arithmetic, logic, shift and compare occupy one contiguous block
   assign aluClass = Opcode inside {[controlPkg::ADD:controlPkg::NEG]};

   always_comb begin
      AluOp    = controlPkg::FnA;
      Op1Sel   = controlPkg::Op1Rd1;
      Op2Sel   = controlPkg::Op2Imm;
      ImmSel   = controlPkg::ImmLong;
      WdSel    = controlPkg::WdAlu;
      PcSel    = controlPkg::Pc1;
      LrSel    = controlPkg::LrSys;
      Rs1Sel   = controlPkg::Rs1Ra;
      AluEn    = 1'b0;
      AluWe    = 1'b0;
      LrEn     = 1'b0;
      LrWe     = 1'b0;
      RegWe    = 1'b0;
      PcWe     = 1'b0;
      StatusWe = 1'b0;
      if (State == controlPkg::execute) begin
         case (Cycle)
            controlPkg::Cycle0: begin
               case (Opcode)
                  controlPkg::ADD, controlPkg::ADDI, controlPkg::ADDIB: AluOp = controlPkg::FnADD;
                  controlPkg::ADC, controlPkg::ADCI, controlPkg::SUC, controlPkg::SUCI:
                     AluOp = controlPkg::FnADC;   // carry forms share one ALU function
                  controlPkg::SUB, controlPkg::SUBI, controlPkg::SUBIB, controlPkg::CMP,
                  controlPkg::CMPI: AluOp = controlPkg::FnSUB;
                  controlPkg::AND:  AluOp = controlPkg::FnAND;
                  controlPkg::OR:   AluOp = controlPkg::FnOR;
                  controlPkg::XOR:  AluOp = controlPkg::FnXOR;
                  controlPkg::NOT:  AluOp = controlPkg::FnNOT;
                  controlPkg::NAND: AluOp = controlPkg::FnNAND;
                  controlPkg::NOR:  AluOp = controlPkg::FnNOR;
                  controlPkg::LSL:  AluOp = controlPkg::FnLSL;
                  controlPkg::LSR:  AluOp = controlPkg::FnLSR;
                  controlPkg::ASR:  AluOp = controlPkg::FnASR;
                  controlPkg::NEG:  AluOp = controlPkg::FnNEG;
                  controlPkg::LUI:  AluOp = controlPkg::FnLUI;
                  controlPkg::LLI:  AluOp = controlPkg::FnLLI;
                  default:          AluOp = controlPkg::FnADD;   // address and branch target
               endcase
               case (Opcode)
                  controlPkg::ADD, controlPkg::ADC, controlPkg::SUB, controlPkg::SUC,
                  controlPkg::CMP, controlPkg::AND, controlPkg::OR, controlPkg::XOR,
                  controlPkg::NAND, controlPkg::NOR: Op2Sel = controlPkg::Op2Rd2;
                  controlPkg::ADDI, controlPkg::ADCI, controlPkg::SUBI, controlPkg::SUCI,
                  controlPkg::CMPI, controlPkg::LSL, controlPkg::LSR, controlPkg::ASR,
                  controlPkg::LDW, controlPkg::STW: ImmSel = controlPkg::ImmShort;
                  controlPkg::ADDIB, controlPkg::SUBIB, controlPkg::LUI,
                  controlPkg::LLI: Rs1Sel = controlPkg::Rs1Rd;   // destination is also source
                  default: ;
               endcase
               if (aluClass) begin
                  PcWe     = 1'b1;
                  StatusWe = 1'b1;
                  RegWe    = !(Opcode inside {controlPkg::CMP, controlPkg::CMPI});
               end
               case (Opcode)
                  controlPkg::LUI, controlPkg::LLI: begin
                     AluEn = 1'b1;
                     RegWe = 1'b1;
                     PcWe  = 1'b1;
                  end
                  controlPkg::LDW, controlPkg::STW: begin
                     AluEn = 1'b1;
                     AluWe = 1'b1;   // latch address for the bus cycle
                  end
                  controlPkg::BRANCH: begin
                     PcWe = 1'b1;
                     case (BranchCode)
                        controlPkg::RET: begin
                           LrEn  = 1'b1;   // link register onto sysbus
                           PcSel = controlPkg::PcSysbus;
                        end
                        controlPkg::JMP: begin
                           ImmSel = controlPkg::ImmShort;
                           PcSel  = controlPkg::PcAluOut;
                        end
                        default: begin
                           Op1Sel = controlPkg::Op1Pc;   // PC relative target
                           AluEn  = 1'b1;
                           if (BranchTaken) begin
                              PcSel = controlPkg::PcAluOut;
                              if (BranchCode == controlPkg::BWL) begin
                                 LrWe  = 1'b1;
                                 LrSel = controlPkg::LrPc;
                              end
                           end
                        end
                     endcase
                  end
                  default: ;
               endcase
            end
            controlPkg::Cycle1: begin
               ImmSel = controlPkg::ImmShort;   // address back out for ALE
               AluOp  = controlPkg::FnADD;
               AluEn  = 1'b1;
            end
            controlPkg::Cycle2: begin
               Rs1Sel = controlPkg::Rs1Rd;
               AluOp  = controlPkg::FnA;   // pass store data through
               AluWe  = 1'b1;
               AluEn  = 1'b1;
            end
            controlPkg::Cycle3: begin
               AluEn = (Opcode == controlPkg::STW);   // hold store data
            end
            default: begin
               PcWe = 1'b1;
               if (Opcode == controlPkg::LDW) begin
                  WdSel = controlPkg::WdSys;   // load data from memory
                  RegWe = 1'b1;
               end else begin
                  AluEn = 1'b1;
               end
            end
         endcase
      end
   end

endmodule

// File: hw/busSequencer.sv
// memory bus strobe sequencing for instruction fetch and load/store cycles

`timescale 1ns/1ps

module busSequencer (
   input  controlPkg::majorStateT State,
   input  controlPkg::cycleT      Cycle,
   input  controlPkg::opcodeT     Opcode,
   output logic                   ALE,
   output logic                   nWE,
   output logic                   nOE,
   output logic                   nME,
   output logic                   ENB,
   output logic                   MemEn,
   output logic                   IrWe,
   output logic                   PcEn
);

   logic aluClass;
   logic isStore;

   assign aluClass = Opcode inside {[controlPkg::ADD:controlPkg::NEG]};
   assign isStore  = (Opcode == controlPkg::STW);

   always_comb begin
      ALE   = 1'b0;
      nWE   = 1'b1;
      nOE   = 1'b0;
      nME   = 1'b1;
      ENB   = 1'b0;
      MemEn = 1'b0;
      IrWe  = 1'b0;
      PcEn  = 1'b0;
      if (State == controlPkg::fetch) begin
         case (Cycle)
            controlPkg::Cycle0: begin
               ALE  = 1'b1;   // PC address latched by memory
               nOE  = 1'b1;
               PcEn = 1'b1;
            end
            controlPkg::Cycle1: begin
               nME   = 1'b0;
               MemEn = 1'b1;
            end
            controlPkg::Cycle2: begin
               nME   = 1'b0;
               MemEn = 1'b1;
               ENB   = 1'b1;   // instruction onto sysbus
            end
            default: begin
               MemEn = 1'b1;
               IrWe  = 1'b1;
            end
         endcase
      end else begin
         case (Cycle)
            controlPkg::Cycle0: PcEn = aluClass;
            controlPkg::Cycle1: begin
               ALE = 1'b1;   // data address from ALU latch
               nOE = 1'b1;
            end
            controlPkg::Cycle2: begin
               nME   = 1'b0;
               nOE   = isStore;
               MemEn = ~isStore;
            end
            controlPkg::Cycle3: begin
               nME   = 1'b0;
               nOE   = isStore;
               nWE   = ~isStore;   // write strobe
               MemEn = ~isStore;
               ENB   = ~isStore;
            end
            default: begin
               nOE   = isStore;
               nWE   = ~isStore;
               MemEn = ~isStore;
            end
         endcase
      end
   end

endmodule

// File: hw/controlTop.sv
// control unit top level joining the cycle sequencer, flag unit and both decoders

`timescale 1ns/1ps
`include "control_config.svh"

module controlTop (
   input  logic                                    Clock,
   input  logic                                    nReset,
   input  logic [`OPCODE_WIDTH+`BRANCH_WIDTH-1:0]  OpcodeCondIn,
   input  logic [`FLAG_WIDTH-1:0]                  Flags,
   output controlPkg::aluFunctionT                 AluOp,
   output controlPkg::op1SelectT                   Op1Sel,
   output controlPkg::op2SelectT                   Op2Sel,
   output controlPkg::immSelectT                   ImmSel,
   output controlPkg::wdSelectT                    WdSel,
   output controlPkg::pcSelectT                    PcSel,
   output controlPkg::lrSelectT                    LrSel,
   output controlPkg::rs1SelectT                   Rs1Sel,
   output logic                                    AluEn,
   output logic                                    AluWe,
   output logic                                    LrEn,
   output logic                                    LrWe,
   output logic                                    RegWe,
   output logic                                    PcWe,
   output logic                                    StatusWe,
   output logic                                    ALE,
   output logic                                    nWE,
   output logic                                    nOE,
   output logic                                    nME,
   output logic                                    ENB,
   output logic                                    MemEn,
   output logic                                    IrWe,
   output logic                                    PcEn,
   output logic                                    CFlag
);

   controlPkg::opcodeT     opcode;
   controlPkg::branchT     branchCode;
   controlPkg::majorStateT state;
   controlPkg::cycleT      cycle;
   logic                   branchTaken;

   // opcode in the upper bits, condition in the lower bits
   assign opcode     = controlPkg::opcodeT'(OpcodeCondIn[`OPCODE_WIDTH+`BRANCH_WIDTH-1:`BRANCH_WIDTH]);
   assign branchCode = controlPkg::branchT'(OpcodeCondIn[`BRANCH_WIDTH-1:0]);

   cycleSequencer sequencer (
      .Clock(Clock), .nReset(nReset), .Opcode(opcode), .State(state), .Cycle(cycle)
   );

   flagUnit flags (
      .Clock(Clock), .nReset(nReset), .Flags(Flags), .StatusWe(StatusWe),
      .BranchCode(branchCode), .CFlag(CFlag), .BranchTaken(branchTaken)
   );

   datapathDecoder datapath (
      .State(state), .Cycle(cycle), .Opcode(opcode), .BranchCode(branchCode),
      .BranchTaken(branchTaken), .AluOp(AluOp), .Op1Sel(Op1Sel), .Op2Sel(Op2Sel),
      .ImmSel(ImmSel), .WdSel(WdSel), .PcSel(PcSel), .LrSel(LrSel), .Rs1Sel(Rs1Sel),
      .AluEn(AluEn), .AluWe(AluWe), .LrEn(LrEn), .LrWe(LrWe), .RegWe(RegWe),
      .PcWe(PcWe), .StatusWe(StatusWe)
   );

   busSequencer bus (
      .State(state), .Cycle(cycle), .Opcode(opcode), .ALE(ALE), .nWE(nWE), .nOE(nOE),
      .nME(nME), .ENB(ENB), .MemEn(MemEn), .IrWe(IrWe), .PcEn(PcEn)
   );

endmodule

// File: verif/controlTb.sv
// testbench for the control unit, replaying instruction vectors from a test file

`timescale 1ns/1ps
`include "control_config.svh"

module controlTb;

   localparam int MaxTests = 64;

   logic                                   Clock;
   logic                                   nReset;
   logic [`OPCODE_WIDTH+`BRANCH_WIDTH-1:0] OpcodeCondIn;
   logic [`FLAG_WIDTH-1:0]                 Flags;
   controlPkg::aluFunctionT                AluOp;
   controlPkg::op1SelectT                  Op1Sel;
   controlPkg::op2SelectT                  Op2Sel;
   controlPkg::immSelectT                  ImmSel;
   controlPkg::wdSelectT                   WdSel;
   controlPkg::pcSelectT                   PcSel;
   controlPkg::lrSelectT                   LrSel;
   controlPkg::rs1SelectT                  Rs1Sel;
   logic AluEn, AluWe, LrEn, LrWe, RegWe, PcWe, StatusWe;
   logic ALE, nWE, nOE, nME, ENB, MemEn, IrWe, PcEn, CFlag;

   string                    names [MaxTests];
   logic [`OPCODE_WIDTH-1:0] opcodes [MaxTests];
   logic [`BRANCH_WIDTH-1:0] branches [MaxTests];
   logic [`FLAG_WIDTH-1:0]   flagsIn [MaxTests];
   logic [3:0]               expAluOp [MaxTests];
   logic [1:0]               expPcSel [MaxTests];
   logic                     expRegWe [MaxTests];
   logic                     expCFlag [MaxTests];
   int                       lengths [MaxTests];
   int                       testCount;
   int                       cycleCount = 0;
   int                       cycleLimit = 0;   // set once the vectors are loaded

   controlTop uut (.*);

   initial begin
      Clock = 1'b0;
      forever #4 Clock = ~Clock;
   end

   always @(posedge Clock) begin
      cycleCount <= cycleCount + 1;
      if (cycleLimit > 0 && cycleCount > cycleLimit) begin
         abortRun("timeout: the control unit did not finish the tests in time");
      end
   end

   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("Verification failed");
      $fatal(1, "run aborted");
   endtask

   task automatic reportMismatch(input string testName, input string expected,
                                 input string actual);
      abortRun($sformatf("ERROR %s expected %s actual %s", testName, expected, actual));
   endtask

   task automatic checkAluOp(input string testName, input controlPkg::aluFunctionT expected,
                             input controlPkg::aluFunctionT actual);
      if (actual !== expected) begin
         reportMismatch({testName, " AluOp"}, expected.name(), $sformatf("%0d", actual));
      end
   endtask

   task automatic checkPcSel(input string testName, input controlPkg::pcSelectT expected,
                             input controlPkg::pcSelectT actual);
      if (actual !== expected) begin
         reportMismatch({testName, " PcSel"}, expected.name(), $sformatf("%0d", actual));
      end
   endtask

   task automatic checkWdSel(input string testName, input controlPkg::wdSelectT expected,
                             input controlPkg::wdSelectT actual);
      if (actual !== expected) begin
         reportMismatch({testName, " WdSel"}, expected.name(), $sformatf("%0d", actual));
      end
   endtask

   task automatic checkLrSel(input string testName, input controlPkg::lrSelectT expected,
                             input controlPkg::lrSelectT actual);
      if (actual !== expected) begin
         reportMismatch({testName, " LrSel"}, expected.name(), $sformatf("%0d", actual));
      end
   endtask

   task automatic checkOp1Sel(input string testName, input controlPkg::op1SelectT expected,
                              input controlPkg::op1SelectT actual);
      if (actual !== expected) begin
         reportMismatch({testName, " Op1Sel"}, expected.name(), $sformatf("%0d", actual));
      end
   endtask

   task automatic checkOp2Sel(input string testName, input controlPkg::op2SelectT expected,
                              input controlPkg::op2SelectT actual);
      if (actual !== expected) begin
         reportMismatch({testName, " Op2Sel"}, expected.name(), $sformatf("%0d", actual));
      end
   endtask

   task automatic checkImmSel(input string testName, input controlPkg::immSelectT expected,
                              input controlPkg::immSelectT actual);
      if (actual !== expected) begin
         reportMismatch({testName, " ImmSel"}, expected.name(), $sformatf("%0d", actual));
      end
   endtask

   task automatic checkRs1Sel(input string testName, input controlPkg::rs1SelectT expected,
                              input controlPkg::rs1SelectT actual);
      if (actual !== expected) begin
         reportMismatch({testName, " Rs1Sel"}, expected.name(), $sformatf("%0d", actual));
      end
   endtask

   task automatic checkBit(input string testName, input logic expected, input logic actual);
      if (actual !== expected) begin
         reportMismatch(testName, $sformatf("%b", expected), $sformatf("%b", actual));
      end
   endtask

   task automatic readTests;
      int         fd;
      int         count;
      string      line;
      string      name;
      logic [4:0] op;
      logic [2:0] br;
      logic [3:0] fl;
      logic [3:0] alu;
      logic [1:0] pc;
      logic       rw;
      logic       cf;
      int         len;
      fd = $fopen("verif/control_tests.txt", "r");
      if (fd == 0) begin
         abortRun("cannot open the test vector file verif/control_tests.txt");
      end
      testCount = 0;
      while (!$feof(fd)) begin
         line = "";
         count = $fgets(line, fd);
         if (count > 0 && line.len() > 1 && line[0] != "#") begin   // skip comments
            count = $sscanf(line, "%s %h %h %h %h %h %b %b %d",
                            name, op, br, fl, alu, pc, rw, cf, len);
            if (count != 9 || testCount >= MaxTests) begin
               abortRun({"malformed or surplus test vector line: ", line});
            end
            names[testCount]    = name;
            opcodes[testCount]  = op;
            branches[testCount] = br;
            flagsIn[testCount]  = fl;
            expAluOp[testCount] = alu;
            expPcSel[testCount] = pc;
            expRegWe[testCount] = rw;
            expCFlag[testCount] = cf;
            lengths[testCount]  = len;
            testCount++;
         end
      end
      $fclose(fd);
   endtask

   // one instruction, sampled on falling edges; k counts cycles from ALE
   task automatic runTest(input int i);
      string tn;
      int    k;
      int    len;
      logic  isLoad;
      logic  isStore;
      logic  isAlu;
      logic  isBranch;
      logic  isRet;
      logic  isCond;
      logic  isBwl;
      logic  regPair;
      logic  shortImm;
      logic  rdSource;
      tn       = names[i];
      len      = lengths[i];
      isLoad   = (opcodes[i] == controlPkg::LDW);
      isStore  = (opcodes[i] == controlPkg::STW);
      isAlu    = (opcodes[i] <= controlPkg::NEG);   // arithmetic, logic, shift and compare
      isBranch = (opcodes[i] == controlPkg::BRANCH);
      isRet    = isBranch && (branches[i] == controlPkg::RET);
      isCond   = isBranch && !isRet && (branches[i] != controlPkg::JMP);
      isBwl    = isBranch && (branches[i] == controlPkg::BWL);
      regPair  = opcodes[i] inside {controlPkg::ADD, controlPkg::ADC, controlPkg::SUB,
                                    controlPkg::SUC, controlPkg::CMP, controlPkg::AND,
                                    controlPkg::OR, controlPkg::XOR, controlPkg::NAND,
                                    controlPkg::NOR};
      shortImm = (opcodes[i] inside {controlPkg::ADDI, controlPkg::ADCI, controlPkg::SUBI,
                                     controlPkg::SUCI, controlPkg::CMPI, controlPkg::LSL,
                                     controlPkg::LSR, controlPkg::ASR, controlPkg::LDW,
                                     controlPkg::STW}) ||
                 (isBranch && branches[i] == controlPkg::JMP);
      rdSource = opcodes[i] inside {controlPkg::ADDIB, controlPkg::SUBIB, controlPkg::LUI,
                                    controlPkg::LLI};
      while (ALE !== 1'b1) begin
         @(negedge Clock);
      end
      @(posedge Clock);
      OpcodeCondIn <= {opcodes[i], branches[i]};   // held until next fetch Cycle1
      Flags        <= flagsIn[i];
      for (k = 1; k <= len; k++) begin
         @(negedge Clock);
         checkBit({tn, " ALE"}, (k == len) || (len == 9 && k == 5), ALE);
         checkBit({tn, " IrWe"}, (k == 3), IrWe);
         checkBit({tn, " RegWe"}, (k == len - 1) ? expRegWe[i] : 1'b0, RegWe);
         checkBit({tn, " PcWe"}, (k == len - 1), PcWe);
         checkBit({tn, " StatusWe"}, (k == 4) && isAlu, StatusWe);
         checkBit({tn, " PcEn"}, (k == len) || (k == 4 && isAlu), PcEn);
         checkBit({tn, " nME"}, !(k == 1 || k == 2 || (len == 9 && (k == 6 || k == 7))), nME);
         checkBit({tn, " ENB"}, (k == 2) || (isLoad && k == 7), ENB);
         checkBit({tn, " nWE"}, !(isStore && (k == 7 || k == 8)), nWE);
         if (k == 4) begin   // execute Cycle0
            checkAluOp(tn, controlPkg::aluFunctionT'(expAluOp[i]), AluOp);
            checkPcSel(tn, controlPkg::pcSelectT'(expPcSel[i]), PcSel);
            checkBit({tn, " LrWe"}, isBwl, LrWe);
            checkBit({tn, " LrEn"}, isRet, LrEn);
            checkBit({tn, " AluWe"}, isLoad || isStore, AluWe);
            checkLrSel(tn, isBwl ? controlPkg::LrPc : controlPkg::LrSys, LrSel);
            checkOp1Sel(tn, isCond ? controlPkg::Op1Pc : controlPkg::Op1Rd1, Op1Sel);
            checkOp2Sel(tn, regPair ? controlPkg::Op2Rd2 : controlPkg::Op2Imm, Op2Sel);
            checkImmSel(tn, shortImm ? controlPkg::ImmShort : controlPkg::ImmLong, ImmSel);
            checkRs1Sel(tn, rdSource ? controlPkg::Rs1Rd : controlPkg::Rs1Ra, Rs1Sel);
         end
         if (k >= 4 && k < len) begin
            checkWdSel(tn, (isLoad && k == 8) ? controlPkg::WdSys : controlPkg::WdAlu, WdSel);
         end
         if (len == 9 && k >= 5 && k < len) begin   // no output enable on address or write
            checkBit({tn, " nOE"}, (k == 5) || isStore, nOE);
         end
      end
      checkBit({tn, " CFlag"}, expCFlag[i], CFlag);
   endtask

   initial begin
      nReset       = 1'b0;
      OpcodeCondIn = '0;
      Flags        = '0;
      readTests();
      cycleLimit = 9 * testCount + 20;
      repeat (3) @(posedge Clock);
      nReset <= 1'b1;
      @(negedge Clock);
      checkBit("reset ALE", 1'b1, ALE);
      checkBit("reset PcEn", 1'b1, PcEn);
      checkBit("reset nME", 1'b1, nME);
      checkBit("reset nOE", 1'b1, nOE);
      checkBit("reset RegWe", 1'b0, RegWe);
      checkBit("reset PcWe", 1'b0, PcWe);
      checkBit("reset IrWe", 1'b0, IrWe);
      checkBit("reset LrWe", 1'b0, LrWe);
      checkBit("reset LrEn", 1'b0, LrEn);
      checkBit("reset AluWe", 1'b0, AluWe);
      checkBit("reset AluEn", 1'b0, AluEn);
      checkBit("reset StatusWe", 1'b0, StatusWe);
      checkBit("reset MemEn", 1'b0, MemEn);
      checkBit("reset ENB", 1'b0, ENB);
      for (int i = 0; i < testCount; i++) begin
         runTest(i);
      end
      $display("Verification passed");
      $finish;
   end

endmodule

// File: verif/control_tests.txt
# name opcode branch flags(VNZC) aluOp pcSel regWe cFlag length, all hex except last three
# regWe is for the last execute cycle, cFlag is read at the next fetch Cycle0
add     00 0 1 1 0 1 1 5
addi    01 0 0 1 0 1 0 5
adc     03 0 1 2 0 1 1 5
sub     05 0 0 3 0 1 0 5
cmp     0a 0 3 3 0 0 1 5
bneTkn  1a 1 0 1 1 0 1 5
beNot   1a 2 c 1 0 0 1 5
cmpi    0b 0 4 3 0 0 0 5
bltTkn  1a 3 0 1 1 0 0 5
bgeNot  1a 4 f 1 0 0 0 5
and     0c 0 0 5 0 1 0 5
beTkn   1a 2 3 1 1 0 0 5
bgeTkn  1a 4 0 1 1 0 0 5
bwl     1a 5 0 1 1 0 0 5
ret     1a 6 f 1 2 0 0 5
or      0d 0 1 6 0 1 1 5
lui     16 0 0 e 0 1 1 5
lli     17 0 0 f 0 1 1 5
jmp     1a 7 0 1 1 0 1 5
xor     0e 0 0 7 0 1 0 5
lsl     12 0 1 b 0 1 1 5
neg     15 0 0 4 0 1 0 5
ldw     18 0 f 1 0 1 0 9
stw     19 0 f 1 0 0 0 9

// File: verilog.f
+incdir+hw
hw/controlPkg.sv
hw/cycleSequencer.sv
hw/flagUnit.sv
hw/datapathDecoder.sv
hw/busSequencer.sv
hw/controlTop.sv
verif/controlTb.sv
